// ==== verilog/leaf_net_pkg.sv ====
`default_nettype none

package leaf_net_pkg;

    // Packet field widths.
    localparam int unsigned PACKET_BITS  = 49;
    localparam int unsigned PAYLOAD_BITS = 32;
    localparam int unsigned LEAF_BITS    = 5;
    localparam int unsigned PORT_BITS    = 4;
    localparam int unsigned ADDR_BITS    = 7;

    // Field positions, valid bit on top and payload at the bottom.
    localparam int unsigned VLD_POS  = PACKET_BITS - 1;
    localparam int unsigned LEAF_LSB = VLD_POS - LEAF_BITS;
    localparam int unsigned PORT_LSB = LEAF_LSB - PORT_BITS;
    localparam int unsigned ADDR_LSB = PORT_LSB - ADDR_BITS;

    // Control packets arrive on this port.
    localparam logic [PORT_BITS-1:0] CTRL_PORT = '0;

endpackage

`default_nettype wire

// ==== verilog/leaf_kernel_pkg.sv ====
`default_nettype none

package leaf_kernel_pkg;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_XOR = 2'd2,
        OP_MAX = 2'd3
    } kernel_op_t;

    typedef enum logic {
        LANE_EMPTY = 1'b0,
        LANE_FULL  = 1'b1
    } lane_state_t;

    // Control address map.
    localparam int unsigned CFG_OP_LANE0  = 0;
    localparam int unsigned CFG_OP_LANE1  = 1;
    localparam int unsigned CFG_DST_LANE0 = 2;
    localparam int unsigned CFG_DST_LANE1 = 3;

endpackage

`default_nettype wire

// ==== verilog/leaf_port_fifo.sv ====
`default_nettype none

module leaf_port_fifo import leaf_net_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  logic [PAYLOAD_BITS-1:0] din,
    input  logic                    ack,
    output logic                    full,
    output logic                    vld,
    output logic [PAYLOAD_BITS-1:0] dout
);

    localparam int unsigned PTR_BITS = $clog2(FIFO_DEPTH);

    logic [PAYLOAD_BITS-1:0] mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0]     wr_ptr;
    logic [PTR_BITS-1:0]     rd_ptr;
    logic [PTR_BITS:0]       count;
    logic [PTR_BITS:0]       count_next;
    logic                    pop;

    assign pop  = ack && vld;
    assign vld  = (count != '0);
    assign dout = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (wr_en && !pop) begin
            count_next = count + 1'b1;
        end else if (!wr_en && pop) begin
            count_next = count - 1'b1;
        end
    end

    // Full looks past the write in flight, the receiver strobes one cycle late.
    assign full = (count_next == (PTR_BITS + 1)'(FIFO_DEPTH));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            count <= count_next;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/leaf_packet_rx.sv ====
`default_nettype none

module leaf_packet_rx import leaf_net_pkg::*, leaf_kernel_pkg::*; #(
    parameter int unsigned LEAF_ID = 5
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [PACKET_BITS-1:0]         din,
    input  logic [3:0]                     fifo_full,
    output logic [3:0]                     fifo_wr,
    output logic [PAYLOAD_BITS-1:0]        fifo_data,
    output kernel_op_t                     lane_op [2],
    output logic [LEAF_BITS+PORT_BITS-1:0] lane_dst [2],
    output logic                           overflow
);

    logic [LEAF_BITS-1:0]    pkt_leaf;
    logic [PORT_BITS-1:0]    pkt_port;
    logic [ADDR_BITS-1:0]    pkt_addr;
    logic [PAYLOAD_BITS-1:0] pkt_payload;
    logic                    pkt_hit;
    logic                    is_data;
    logic                    is_ctrl;
    logic [1:0]              port_idx;

    assign pkt_leaf    = din[LEAF_LSB +: LEAF_BITS];
    assign pkt_port    = din[PORT_LSB +: PORT_BITS];
    assign pkt_addr    = din[ADDR_LSB +: ADDR_BITS];
    assign pkt_payload = din[PAYLOAD_BITS-1:0];

    // Keep only valid packets for this leaf.
    assign pkt_hit = din[VLD_POS] && (pkt_leaf == LEAF_BITS'(LEAF_ID));
    assign is_ctrl = pkt_hit && (pkt_port == CTRL_PORT);
    assign is_data = pkt_hit && (pkt_port >= PORT_BITS'(1)) && (pkt_port <= PORT_BITS'(4));

    // Ports 1 to 4 map onto FIFOs 0 to 3.
    assign port_idx = 2'(pkt_port - PORT_BITS'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fifo_wr     <= '0;
            overflow    <= 1'b0;
            lane_op[0]  <= OP_ADD;
            lane_op[1]  <= OP_ADD;
            lane_dst[0] <= '0;
            lane_dst[1] <= '0;
        end else begin
            fifo_wr <= '0;
            if (is_data) begin
                if (fifo_full[port_idx]) begin
                    overflow <= 1'b1;
                end else begin
                    fifo_wr[port_idx] <= 1'b1;
                end
            end
            if (is_ctrl) begin
                case (pkt_addr)
                    ADDR_BITS'(CFG_OP_LANE0):  lane_op[0]  <= kernel_op_t'(pkt_payload[1:0]);
                    ADDR_BITS'(CFG_OP_LANE1):  lane_op[1]  <= kernel_op_t'(pkt_payload[1:0]);
                    ADDR_BITS'(CFG_DST_LANE0): lane_dst[0] <= pkt_payload[LEAF_BITS+PORT_BITS-1:0];
                    ADDR_BITS'(CFG_DST_LANE1): lane_dst[1] <= pkt_payload[LEAF_BITS+PORT_BITS-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_data) begin
            fifo_data <= pkt_payload;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/leaf_kernel_lane.sv ====
`default_nettype none

module leaf_kernel_lane import leaf_net_pkg::*, leaf_kernel_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    a_vld,
    input  logic [PAYLOAD_BITS-1:0] a_data,
    input  logic                    b_vld,
    input  logic [PAYLOAD_BITS-1:0] b_data,
    input  kernel_op_t              op,
    input  logic                    res_ack,
    output logic                    a_ack,
    output logic                    b_ack,
    output logic                    res_vld,
    output logic [PAYLOAD_BITS-1:0] res_data
);

    lane_state_t             state;
    logic                    pop;
    logic [PAYLOAD_BITS-1:0] op_result;

    // Both heads leave together.
    assign pop   = (state == LANE_EMPTY) && a_vld && b_vld;
    assign a_ack = pop;
    assign b_ack = pop;

    always_comb begin
        case (op)
            OP_ADD:  op_result = a_data + b_data;
            OP_SUB:  op_result = a_data - b_data;
            OP_XOR:  op_result = a_data ^ b_data;
            OP_MAX:  op_result = (a_data > b_data) ? a_data : b_data;
            default: op_result = a_data + b_data;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= LANE_EMPTY;
            res_vld <= 1'b0;
        end else begin
            case (state)
                LANE_EMPTY: begin
                    if (pop) begin
                        state <= LANE_FULL;
                    end
                end
                LANE_FULL: begin
                    // Result is offered one cycle after the pop.
                    if (res_ack) begin
                        state   <= LANE_EMPTY;
                        res_vld <= 1'b0;
                    end else begin
                        res_vld <= 1'b1;
                    end
                end
                default: state <= LANE_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            res_data <= op_result;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/leaf_packet_tx.sv ====
`default_nettype none

module leaf_packet_tx import leaf_net_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           resend,
    input  logic [1:0]                     res_vld,
    input  logic [PAYLOAD_BITS-1:0]        res_data [2],
    input  logic [LEAF_BITS+PORT_BITS-1:0] lane_dst [2],
    output logic [1:0]                     res_ack,
    output logic [PACKET_BITS-1:0]         dout
);

    logic                   rr;
    logic [1:0]             grant;
    logic                   sel;
    logic [ADDR_BITS-1:0]   seq [2];
    logic [PACKET_BITS-1:0] new_pkt;
    logic [PACKET_BITS-1:0] pkt_q;
    logic                   pkt_vld;

    // rr names the lane that wins a tie.
    always_comb begin
        grant = 2'b00;
        if (res_vld[0] && (!res_vld[1] || !rr)) begin
            grant[0] = 1'b1;
        end else if (res_vld[1]) begin
            grant[1] = 1'b1;
        end
    end

    assign sel     = grant[1];
    assign res_ack = resend ? 2'b00 : grant;

    always_comb begin
        new_pkt                               = '0;
        new_pkt[VLD_POS]                      = 1'b1;
        new_pkt[LEAF_LSB +: LEAF_BITS]        = lane_dst[sel][PORT_BITS +: LEAF_BITS];
        new_pkt[PORT_LSB +: PORT_BITS]        = lane_dst[sel][PORT_BITS-1:0];
        new_pkt[ADDR_LSB +: ADDR_BITS]        = seq[sel];
        new_pkt[PAYLOAD_BITS-1:0]             = res_data[sel];
    end

    // The whole pipe stalls while resend is high.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr      <= 1'b0;
            seq[0]  <= '0;
            seq[1]  <= '0;
            pkt_vld <= 1'b0;
            dout    <= '0;
        end else if (resend) begin
            dout <= '0;
        end else begin
            dout    <= pkt_vld ? pkt_q : '0;
            pkt_vld <= |grant;
            if (|grant) begin
                rr       <= !sel;
                seq[sel] <= seq[sel] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resend && |grant) begin
            pkt_q <= new_pkt;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/leaf_interface.sv ====
`default_nettype none

module leaf_interface import leaf_net_pkg::*, leaf_kernel_pkg::*; #(
    parameter int unsigned LEAF_ID    = 5,
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [PACKET_BITS-1:0]  din,
    input  logic                    resend,
    input  logic [3:0]              port_ack,
    input  logic [1:0]              res_vld,
    input  logic [PAYLOAD_BITS-1:0] res_data [2],
    output logic [PACKET_BITS-1:0]  dout,
    output wire  [3:0]              port_vld,
    output wire  [PAYLOAD_BITS-1:0] port_data [4],
    output logic [1:0]              res_ack,
    output kernel_op_t              lane_op [2],
    output logic                    overflow
);

    logic [3:0]                     fifo_wr;
    wire  [3:0]                     fifo_full;
    logic [PAYLOAD_BITS-1:0]        fifo_data;
    logic [LEAF_BITS+PORT_BITS-1:0] lane_dst [2];

    leaf_packet_rx #(
        .LEAF_ID(LEAF_ID)
    ) u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .din      (din),
        .fifo_full(fifo_full),
        .fifo_wr  (fifo_wr),
        .fifo_data(fifo_data),
        .lane_op  (lane_op),
        .lane_dst (lane_dst),
        .overflow (overflow)
    );

    // One FIFO per data port, ports 1 to 4.
    for (genvar i = 0; i < 4; i++) begin : g_port
        leaf_port_fifo #(
            .FIFO_DEPTH(FIFO_DEPTH)
        ) u_fifo (
            .clk  (clk),
            .rst_n(rst_n),
            .wr_en(fifo_wr[i]),
            .din  (fifo_data),
            .ack  (port_ack[i]),
            .full (fifo_full[i]),
            .vld  (port_vld[i]),
            .dout (port_data[i])
        );
    end

    leaf_packet_tx u_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .resend  (resend),
        .res_vld (res_vld),
        .res_data(res_data),
        .lane_dst(lane_dst),
        .res_ack (res_ack),
        .dout    (dout)
    );

endmodule

`default_nettype wire

// ==== verilog/leaf_node.sv ====
`default_nettype none

module leaf_node import leaf_net_pkg::*, leaf_kernel_pkg::*; #(
    parameter int unsigned LEAF_ID    = 5,
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [PACKET_BITS-1:0] din,
    input  logic                   resend,
    output logic [PACKET_BITS-1:0] dout,
    output logic                   overflow
);

    wire  [3:0]              port_vld;
    wire  [PAYLOAD_BITS-1:0] port_data [4];
    wire  [3:0]              port_ack;
    wire  [1:0]              res_vld;
    wire  [PAYLOAD_BITS-1:0] res_data [2];
    logic [1:0]              res_ack;
    kernel_op_t              lane_op [2];

    leaf_interface #(
        .LEAF_ID   (LEAF_ID),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_interface (
        .clk      (clk),
        .rst_n    (rst_n),
        .din      (din),
        .resend   (resend),
        .port_ack (port_ack),
        .res_vld  (res_vld),
        .res_data (res_data),
        .dout     (dout),
        .port_vld (port_vld),
        .port_data(port_data),
        .res_ack  (res_ack),
        .lane_op  (lane_op),
        .overflow (overflow)
    );

    // Lane 0 pairs ports 1 and 2, lane 1 pairs ports 3 and 4.
    for (genvar l = 0; l < 2; l++) begin : g_lane
        leaf_kernel_lane u_lane (
            .clk     (clk),
            .rst_n   (rst_n),
            .a_vld   (port_vld[2*l]),
            .a_data  (port_data[2*l]),
            .b_vld   (port_vld[2*l+1]),
            .b_data  (port_data[2*l+1]),
            .op      (lane_op[l]),
            .res_ack (res_ack[l]),
            .a_ack   (port_ack[2*l]),
            .b_ack   (port_ack[2*l+1]),
            .res_vld (res_vld[l]),
            .res_data(res_data[l])
        );
    end

endmodule

`default_nettype wire

// ==== test/leaf_node_props.sv ====
`default_nettype none

module leaf_node_props import leaf_net_pkg::*; (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   resend,
    input logic [PACKET_BITS-1:0] dout,
    input logic [1:0]             res_vld,
    input logic [1:0]             res_ack,
    input logic [3:0]             fifo_wr,
    input logic [3:0]             port_ack,
    input logic [3:0]             port_vld
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] occupancy [4];
    logic [3:0] holds_data;

    // Words written minus words popped, per port FIFO.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                occupancy[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                occupancy[i] <= occupancy[i] + 8'(fifo_wr[i]) - 8'(port_ack[i] && port_vld[i]);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            holds_data[i] = (occupancy[i] != '0);
        end
    end

    a_resend_squash: assert property (
        @(posedge clk) disable iff (!rst_n) resend |=> (dout == '0)
    ) else $error("dout not zero in the cycle after resend");

    // An offered result stays offered until it is taken.
    a_lane0_held: assert property (
        @(posedge clk) disable iff (!rst_n) (res_vld[0] && !res_ack[0]) |=> res_vld[0]
    ) else $error("lane 0 result dropped without res_ack");

    a_lane1_held: assert property (
        @(posedge clk) disable iff (!rst_n) (res_vld[1] && !res_ack[1]) |=> res_vld[1]
    ) else $error("lane 1 result dropped without res_ack");

    a_vld_needs_data: assert property (
        @(posedge clk) disable iff (!rst_n) (port_vld & ~holds_data) == 4'b0000
    ) else $error("port_vld high from an empty FIFO");

endmodule

bind leaf_interface leaf_node_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .resend  (resend),
    .dout    (dout),
    .res_vld (res_vld),
    .res_ack (res_ack),
    .fifo_wr (fifo_wr),
    .port_ack(port_ack),
    .port_vld(port_vld)
);

`default_nettype wire

// ==== test/leaf_node_tb.sv ====
`default_nettype none

module leaf_node_tb import leaf_net_pkg::*, leaf_kernel_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned LEAF_ID    = 5;
    localparam int unsigned OTHER_LEAF = 6;
    localparam int unsigned FIFO_DEPTH = 4;

    typedef enum logic [2:0] {
        K_CFG,
        K_DATA,
        K_HOLD,
        K_RELEASE,
        K_FLAG
    } row_kind_t;

    // One row of the stimulus table, keep marks words the DUT must accept.
    typedef struct packed {
        row_kind_t               kind;
        logic                    vld;
        logic [LEAF_BITS-1:0]    leaf;
        logic [PORT_BITS-1:0]    port;
        logic [ADDR_BITS-1:0]    addr;
        logic [PAYLOAD_BITS-1:0] payload;
        logic                    keep;
    } row_t;

    logic                           clk;
    logic                           rst_n;
    logic [PACKET_BITS-1:0]         din;
    logic                           resend;
    logic [PACKET_BITS-1:0]         dout;
    logic                           overflow;

    row_t                           rows [$];
    logic [31:0]                    lfsr_state;
    logic                           holding;
    logic                           ops_checked;
    logic                           resend_prev;
    kernel_op_t                     model_op [2];
    logic [LEAF_BITS+PORT_BITS-1:0] model_dst [2];
    logic [ADDR_BITS-1:0]           model_seq [2];
    logic [PAYLOAD_BITS-1:0]        port_q [4][$];
    logic [PACKET_BITS-1:0]         exp_q [2][$];

    leaf_node #(
        .LEAF_ID   (LEAF_ID),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .din     (din),
        .resend  (resend),
        .dout    (dout),
        .overflow(overflow)
    );

    always #10 clk = !clk;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(int unsigned n);
        logic [31:0] r;
        r = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [PAYLOAD_BITS-1:0] apply_op(kernel_op_t op,
                                                         logic [PAYLOAD_BITS-1:0] a,
                                                         logic [PAYLOAD_BITS-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            default: return (a > b) ? a : b;
        endcase
    endfunction

    function automatic logic [PACKET_BITS-1:0] make_packet(logic vld,
                                                           logic [LEAF_BITS-1:0] leaf,
                                                           logic [PORT_BITS-1:0] port,
                                                           logic [ADDR_BITS-1:0] addr,
                                                           logic [PAYLOAD_BITS-1:0] payload);
        return {vld, leaf, port, addr, payload};
    endfunction

    task automatic fail_run(string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_packet(string name, logic [PACKET_BITS-1:0] got,
                                  logic [PACKET_BITS-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_op(string name, kernel_op_t got, kernel_op_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic add_row(row_kind_t kind, logic vld, int unsigned leaf, int unsigned port,
                           int unsigned addr, logic [PAYLOAD_BITS-1:0] payload, logic keep);
        rows.push_back(row_t'({kind, vld, LEAF_BITS'(leaf), PORT_BITS'(port),
                               ADDR_BITS'(addr), payload, keep}));
    endtask

    task automatic build_table();
        // Destinations, leaf 9 port 2 and leaf 12 port 7.
        add_row(K_CFG, 1'b1, LEAF_ID, 0, CFG_DST_LANE0, 32'h92, 1'b1);
        add_row(K_CFG, 1'b1, LEAF_ID, 0, CFG_DST_LANE1, 32'hc7, 1'b1);
        for (int unsigned p = 0; p < 4; p++) begin
            add_row(K_CFG, 1'b1, LEAF_ID, 0, CFG_OP_LANE0, p, 1'b1);
            add_row(K_CFG, 1'b1, LEAF_ID, 0, CFG_OP_LANE1, 3 - p, 1'b1);
            add_row(K_CFG, 1'b1, OTHER_LEAF, 0, CFG_OP_LANE0, p ^ 1, 1'b0);
            add_row(K_CFG, 1'b0, LEAF_ID, 0, CFG_DST_LANE1, 32'h92, 1'b0);
            for (int unsigned n = 0; n < 3; n++) begin
                for (int unsigned port = 1; port <= 4; port++) begin
                    add_row(K_DATA, 1'b1, LEAF_ID, port, 0, take_bits(32), 1'b1);
                end
            end
            add_row(K_DATA, 1'b1, OTHER_LEAF, 1, 0, take_bits(32), 1'b0);
            add_row(K_DATA, 1'b0, LEAF_ID, 3, 0, take_bits(32), 1'b0);
            add_row(K_DATA, 1'b1, LEAF_ID, 5, 0, take_bits(32), 1'b0);
        end
        // Flood port 1 while the output is held.
        add_row(K_FLAG, 1'b0, 0, 0, 0, 32'd0, 1'b0);
        add_row(K_HOLD, 1'b0, 0, 0, 0, 32'd0, 1'b0);
        for (int unsigned n = 0; n <= FIFO_DEPTH; n++) begin
            add_row(K_DATA, 1'b1, LEAF_ID, 1, 0, take_bits(32), n < FIFO_DEPTH);
        end
        add_row(K_FLAG, 1'b0, 0, 0, 0, 32'd1, 1'b0);
        add_row(K_RELEASE, 1'b0, 0, 0, 0, 32'd0, 1'b0);
        for (int unsigned n = 0; n < FIFO_DEPTH; n++) begin
            add_row(K_DATA, 1'b1, LEAF_ID, 2, 0, take_bits(32), 1'b1);
        end
        // A dropped word would shift this pair.
        add_row(K_DATA, 1'b1, LEAF_ID, 1, 0, take_bits(32), 1'b1);
        add_row(K_DATA, 1'b1, LEAF_ID, 2, 0, take_bits(32), 1'b1);
    endtask

    task automatic model_config(logic [ADDR_BITS-1:0] addr, logic [PAYLOAD_BITS-1:0] payload);
        case (addr)
            ADDR_BITS'(CFG_OP_LANE0):  model_op[0] = kernel_op_t'(payload[1:0]);
            ADDR_BITS'(CFG_OP_LANE1):  model_op[1] = kernel_op_t'(payload[1:0]);
            ADDR_BITS'(CFG_DST_LANE0): model_dst[0] = payload[LEAF_BITS+PORT_BITS-1:0];
            ADDR_BITS'(CFG_DST_LANE1): model_dst[1] = payload[LEAF_BITS+PORT_BITS-1:0];
            default: ;
        endcase
    endtask

    task automatic model_word(int unsigned port, logic [PAYLOAD_BITS-1:0] word);
        int unsigned             l;
        logic [PAYLOAD_BITS-1:0] a;
        logic [PAYLOAD_BITS-1:0] b;
        port_q[port-1].push_back(word);
        l = (port - 1) / 2;
        if (port_q[2*l].size() != 0 && port_q[2*l+1].size() != 0) begin
            a = port_q[2*l].pop_front();
            b = port_q[2*l+1].pop_front();
            exp_q[l].push_back(make_packet(1'b1, model_dst[l][PORT_BITS +: LEAF_BITS],
                                           model_dst[l][PORT_BITS-1:0], model_seq[l],
                                           apply_op(model_op[l], a, b)));
            model_seq[l] = model_seq[l] + 1'b1;
        end
    endtask

    // Random idle gap after each packet, with random resend cycles in it.
    task automatic send_packet(logic [PACKET_BITS-1:0] pkt);
        int unsigned gaps;
        gaps = 1 + take_bits(2);
        @(posedge clk);
        din    <= pkt;
        resend <= holding;
        repeat (gaps) begin
            @(posedge clk);
            din    <= '0;
            resend <= holding || (take_bits(2) == 32'd3);
        end
    endtask

    task automatic drain_results();
        @(posedge clk);
        resend <= holding;
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic apply_row(row_t r);
        case (r.kind)
            K_CFG: begin
                drain_results();
                if (r.keep) begin
                    model_config(r.addr, r.payload);
                end
                send_packet(make_packet(r.vld, r.leaf, r.port, r.addr, r.payload));
                ops_checked = 1'b0;
            end
            K_DATA: begin
                if (!ops_checked) begin
                    @(negedge clk);
                    compare_op("lane_op[0]", UUT.lane_op[0], model_op[0]);
                    compare_op("lane_op[1]", UUT.lane_op[1], model_op[1]);
                    ops_checked = 1'b1;
                end
                if (r.keep) begin
                    model_word(r.port, r.payload);
                end
                send_packet(make_packet(r.vld, r.leaf, r.port, r.addr, r.payload));
            end
            K_HOLD: begin
                drain_results();
                holding = 1'b1;
                @(posedge clk);
                resend <= 1'b1;
            end
            K_RELEASE: begin
                holding = 1'b0;
                @(posedge clk);
                resend <= 1'b0;
            end
            default: begin
                @(negedge clk);
                compare_flag("overflow", overflow, r.payload[0]);
            end
        endcase
    endtask

    // Lane is picked by the destination the packet carries.
    task automatic check_result(logic [PACKET_BITS-1:0] pkt);
        logic [LEAF_BITS+PORT_BITS-1:0] dst;
        int unsigned                    lane;
        dst  = pkt[PORT_LSB +: LEAF_BITS+PORT_BITS];
        lane = (dst == model_dst[1]) ? 1 : 0;
        if (dst != model_dst[lane]) begin
            fail_run($sformatf("result packet %h carries an unknown destination", pkt));
        end else if (exp_q[lane].size() == 0) begin
            fail_run($sformatf("unexpected result packet %h for lane %0d", pkt, lane));
        end else begin
            compare_packet("dout", pkt, exp_q[lane].pop_front());
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (resend_prev && dout != '0) begin
                fail_run("dout was not zero in the cycle after resend");
            end
            if (dout[VLD_POS]) begin
                check_result(dout);
            end
        end
        resend_prev = resend;
    end

    initial begin
        #1;
        repeat (rows.size() * 40) @(posedge clk);
        fail_run($sformatf("timeout, table not finished within %0d cycles", rows.size() * 40));
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        din          = '0;
        resend       = 1'b0;
        holding      = 1'b0;
        ops_checked  = 1'b0;
        resend_prev  = 1'b0;
        lfsr_state   = 32'ha2813fd1;
        model_op[0]  = OP_ADD;
        model_op[1]  = OP_ADD;
        model_dst[0] = '0;
        model_dst[1] = '0;
        model_seq[0] = '0;
        model_seq[1] = '0;
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        drain_results();
        repeat (20) @(posedge clk);
        compare_flag("overflow", overflow, 1'b1);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== leaf_node.f ====
verilog/leaf_net_pkg.sv
verilog/leaf_kernel_pkg.sv
verilog/leaf_port_fifo.sv
verilog/leaf_packet_rx.sv
verilog/leaf_kernel_lane.sv
verilog/leaf_packet_tx.sv
verilog/leaf_interface.sv
verilog/leaf_node.sv
test/leaf_node_props.sv
test/leaf_node_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the leaf_node testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module leaf_node_tb \
    -f leaf_node.f -o sim_leaf_node
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_leaf_node > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

echo "Simulation passed"
exit 0
